// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= rv_core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
src/rv_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_hazard.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
sim/rv_core_tb.sv

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int reset_cycles = 3;
  localparam int drain_cycles = 6;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  // Program storage holds one word per pc[7:2]
  logic [31:0] imem [64];
  int          prog_len;

  // Writes the ISA model predicts and writes seen on the writeback port
  logic [31:0] exp_rd[$];
  logic [31:0] exp_data[$];
  logic [31:0] got_rd[$];
  logic [31:0] got_data[$];
  int          got_cyc[$];

  int          cycle_count = 0;
  int          cycle_limit = reset_cycles;
  int          rel_cycle;
  int          err_count = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  logic [15:0] lfsr = 16'd63;

  always #20 clk = ~clk;

  rv_core #(
    .REGFILE_FWD (1)
  ) uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc       (pc),
    .instr    (instr),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  // The core fetches combinationally in the cycle it presents pc
  assign instr = imem[pc[7:2]];

  // Outputs settle after the rising edge, so every write is sampled at the falling edge
  always @(negedge clk) begin
    if (rst_n && wb_valid) begin
      got_rd.push_back({27'b0, wb_rd});
      got_data.push_back(wb_data);
      got_cyc.push_back(cycle_count);
    end
  end

  // Each test adds its own budget to the limit before it leaves reset
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the core stopped retiring writes after %0d clock cycles", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // RV32I encoders for the formats the programs use
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[6'(prog_len)] = word;
    prog_len++;
  endtask

  // Rounding the upper part up compensates for the sign of the low 12 bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = v + 32'h800;
    emit(u_type(rd, upper[31:12]));
    emit(i_type(3'b000, rd, rd, v[11:0]));
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // ISA interpreter that walks the program until it reaches the self-loop
  task automatic predict_writes();
    logic [31:0] model_regs [32];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] val;
    logic [31:0] mpc;
    logic        wr;
    logic        taken;
    logic        done;
    int          steps;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    exp_rd.delete();
    exp_data.delete();
    mpc   = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
      w     = imem[mpc[7:2]];
      a     = model_regs[w[19:15]];
      b     = model_regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      wr    = 1'b1;
      taken = 1'b0;
      val   = '0;
      case (w[6:0])
        7'b0110011: begin
          case ({w[31:25], w[14:12]})
            10'h000: val = a + b;
            10'h100: val = a - b;
            10'h001: val = a << b[4:0];
            10'h002: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            10'h004: val = a ^ b;
            10'h005: val = a >> b[4:0];
            10'h006: val = a | b;
            10'h007: val = a & b;
            default: wr = 1'b0;
          endcase
        end
        7'b0010011: begin
          case (w[14:12])
            3'b000:  val = a + imm_i;
            3'b100:  val = a ^ imm_i;
            3'b110:  val = a | imm_i;
            3'b111:  val = a & imm_i;
            default: wr = 1'b0;
          endcase
        end
        7'b0110111: val = {w[31:12], 12'b0};
        7'b1100011: begin
          wr = 1'b0;
          if (w[14:12] == 3'b000) begin
            taken = (a == b);
          end else if (w[14:12] == 3'b001) begin
            taken = (a != b);
          end
        end
        default: wr = 1'b0;
      endcase
      // The port reports x0 writes, but x0 itself keeps reading zero
      if (wr) begin
        exp_rd.push_back({27'b0, w[11:7]});
        exp_data.push_back(val);
        if (w[11:7] != 5'd0) begin
          model_regs[w[11:7]] = val;
        end
      end
      if (taken && imm_b == '0) begin
        done = 1'b1;
      end
      mpc = taken ? mpc + imm_b : mpc + 32'd4;
      steps++;
    end
  endtask

  // Reset goes low first so the old program cannot retire while memory is rewritten
  task automatic begin_program();
    @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0;
    end
    prog_len = 0;
    got_rd.delete();
    got_data.delete();
    got_cyc.delete();
  endtask

  task automatic run_program();
    emit(b_type(3'b000, 5'd0, 5'd0, 13'd0));
    predict_writes();
    cycle_limit += 6 * prog_len + reset_cycles;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    rel_cycle = cycle_count;
    check("pc", pc, 32'h0);
    check("wb_valid", {31'b0, wb_valid}, 32'h0);
    while (got_rd.size() < exp_rd.size()) begin
      @(negedge clk);
    end
    // Anything still in flight would retire within the pipeline depth
    repeat (drain_cycles) @(negedge clk);
    check("write count", got_rd.size(), exp_rd.size());
    for (int i = 0; i < got_rd.size() && i < exp_rd.size(); i++) begin
      check($sformatf("wb_rd[%0d]", i), got_rd[i], exp_rd[i]);
      check($sformatf("wb_data[%0d]", i), got_data[i], exp_data[i]);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("Test %s: ok", name);
    end else begin
      fail_count++;
      $display("Test %s: %0d mismatches", name, err_count - errs_before);
    end
  endtask

  task automatic reset_behavior();
    int errs;
    errs = err_count;
    begin_program();
    emit(i_type(3'b000, 5'd1, 5'd0, 12'd5));
    emit(i_type(3'b000, 5'd2, 5'd0, 12'd6));
    run_program();
    // Fetched in the first cycle after release, so it retires four cycles later
    if (got_cyc.size() > 0) begin
      check("first retire cycle", got_cyc[0], rel_cycle + 4);
    end
    report_test("reset", errs);
  endtask

  task automatic independent_ops();
    int errs;
    int n;
    errs = err_count;
    begin_program();
    for (int r = 1; r <= 4; r++) begin
      load_const(5'(r), rand_bits(32));
    end
    // Three no-ops put the last load out of reach of the hazard unit
    repeat (3) emit(32'h0);
    emit(r_type(7'h00, 3'b000, 5'd10, 5'd1, 5'd2));
    emit(r_type(7'h20, 3'b000, 5'd11, 5'd3, 5'd4));
    emit(r_type(7'h00, 3'b100, 5'd12, 5'd1, 5'd4));
    emit(r_type(7'h00, 3'b010, 5'd13, 5'd2, 5'd3));
    emit(r_type(7'h00, 3'b101, 5'd14, 5'd1, 5'd3));
    run_program();
    n = got_cyc.size();
    if (n >= 5) begin
      for (int i = n - 4; i < n; i++) begin
        check("retire gap", got_cyc[i] - got_cyc[i-1], 1);
      end
    end
    report_test("independent", errs);
  endtask

  task automatic raw_chains();
    int errs;
    errs = err_count;
    begin_program();
    load_const(5'd1, rand_bits(32));
    load_const(5'd2, rand_bits(32));
    emit(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
    emit(r_type(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
    emit(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd5));
    emit(r_type(7'h00, 3'b100, 5'd7, 5'd6, 5'd4));
    emit(r_type(7'h00, 3'b010, 5'd8, 5'd7, 5'd6));
    emit(r_type(7'h00, 3'b001, 5'd9, 5'd6, 5'd2));
    emit(r_type(7'h00, 3'b101, 5'd10, 5'd9, 5'd1));
    emit(i_type(3'b000, 5'd11, 5'd10, 12'(rand_bits(12))));
    emit(i_type(3'b111, 5'd12, 5'd11, 12'(rand_bits(12))));
    emit(i_type(3'b110, 5'd13, 5'd11, 12'(rand_bits(12))));
    emit(i_type(3'b100, 5'd14, 5'd13, 12'(rand_bits(12))));
    emit(u_type(5'd15, 20'(rand_bits(20))));
    emit(r_type(7'h00, 3'b000, 5'd16, 5'd15, 5'd14));
    run_program();
    // The addi of the first constant waits two bubbles behind its lui
    if (got_cyc.size() > 1) begin
      check("stall gap", got_cyc[1] - got_cyc[0], 3);
    end
    report_test("raw chains", errs);
  endtask

  task automatic branch_skips();
    int errs;
    errs = err_count;
    begin_program();
    emit(i_type(3'b000, 5'd1, 5'd0, 12'd5));
    emit(i_type(3'b000, 5'd2, 5'd0, 12'd5));
    emit(b_type(3'b000, 5'd1, 5'd2, 13'd12));
    emit(i_type(3'b000, 5'd3, 5'd0, 12'd1));
    emit(i_type(3'b000, 5'd4, 5'd0, 12'd2));
    // Each taken branch lands on a write, so a lost target shows up
    emit(i_type(3'b000, 5'd5, 5'd0, 12'd3));
    emit(b_type(3'b001, 5'd1, 5'd2, 13'd12));
    emit(i_type(3'b000, 5'd6, 5'd0, 12'd4));
    emit(b_type(3'b001, 5'd1, 5'd0, 13'd12));
    emit(i_type(3'b000, 5'd7, 5'd0, 12'd5));
    emit(i_type(3'b000, 5'd8, 5'd0, 12'd6));
    emit(i_type(3'b000, 5'd9, 5'd0, 12'd7));
    emit(b_type(3'b000, 5'd5, 5'd6, 13'd8));
    emit(i_type(3'b000, 5'd10, 5'd0, 12'd8));
    run_program();
    foreach (got_rd[i]) begin
      if (got_rd[i] inside {3, 4, 7, 8}) begin
        err_count++;
        $display("An instruction skipped by a taken branch wrote x%0d", got_rd[i]);
      end
    end
    // The taken bne and its two flushed slots sit between the x6 and x9 writes
    if (got_cyc.size() > 4) begin
      check("branch retire gap", got_cyc[4] - got_cyc[3], 4);
    end
    report_test("branches", errs);
  endtask

  task automatic x0_writes();
    int errs;
    errs = err_count;
    begin_program();
    emit(i_type(3'b000, 5'd1, 5'd0, 12'd21));
    emit(i_type(3'b000, 5'd0, 5'd0, 12'd77));
    emit(i_type(3'b000, 5'd5, 5'd0, 12'd9));
    emit(u_type(5'd0, 20'hABCDE));
    emit(r_type(7'h00, 3'b000, 5'd6, 5'd0, 5'd0));
    emit(r_type(7'h00, 3'b110, 5'd7, 5'd1, 5'd0));
    run_program();
    // A reader of x0 right after an x0 write must not wait for it
    if (got_cyc.size() > 4) begin
      check("x0 reader gap", got_cyc[2] - got_cyc[1], 1);
      check("x0 reader gap", got_cyc[4] - got_cyc[3], 1);
    end
    report_test("x0 writes", errs);
  endtask

  task automatic unknown_encodings();
    int errs;
    errs = err_count;
    begin_program();
    emit(i_type(3'b000, 5'd1, 5'd0, 12'd11));
    emit(32'hFFFF_FFFF);
    // lw x1,0(x0), sra, slti and blt all fall outside the subset
    emit(32'h0000_2083);
    emit(r_type(7'h20, 3'b101, 5'd1, 5'd1, 5'd1));
    emit(i_type(3'b010, 5'd1, 5'd0, 12'd5));
    emit(b_type(3'b100, 5'd0, 5'd0, 13'd8));
    emit(i_type(3'b000, 5'd2, 5'd1, 12'd1));
    run_program();
    report_test("unknown", errs);
  endtask

  initial begin
    rst_n = 1'b0;
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'h0;
    end
    reset_behavior();
    independent_ops();
    raw_chains();
    branch_skips();
    x0_writes();
    unknown_encodings();
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter int REGFILE_FWD = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  output logic [xlen-1:0]       pc,
  input  logic [31:0]           instr,
  output logic                  wb_valid,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data
);

  logic [xlen-1:0] if_id_pc;
  logic [31:0]     if_id_instr;
  id_ex_t          id_ex;
  dec_t            dec;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  ex_res_t         ex_res;
  ex_res_t         mem_res;
  ex_res_t         wb_res;
  logic            pc_sel;
  logic [xlen-1:0] pc_target;
  logic            pc_stall;
  logic            if_id_stall;
  logic            if_id_flush;
  logic            id_ex_flush;

  // Fetch, a taken branch wins over a stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (pc_sel) begin
      pc <= pc_target;
    end else if (!pc_stall) begin
      pc <= pc + xlen'(4);
    end
  end

  // IF/ID holds the stalled instruction, a flush replaces it with a bubble
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_pc    <= '0;
      if_id_instr <= instr_bubble;
    end else if (if_id_flush) begin
      if_id_pc    <= '0;
      if_id_instr <= instr_bubble;
    end else if (!if_id_stall) begin
      if_id_pc    <= pc;
      if_id_instr <= instr;
    end
  end

  rv_decode u_decode (
    .instr (if_id_instr),
    .dec   (dec)
  );

  rv_regfile #(
    .REGFILE_FWD (REGFILE_FWD)
  ) u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wb      (wb_res)
  );

  rv_hazard #(
    .REGFILE_FWD (REGFILE_FWD)
  ) u_hazard (
    .dec          (dec),
    .ex_rd        (id_ex.dec.rd),
    .ex_reg_write (id_ex.dec.reg_write),
    .mem          (mem_res),
    .wb           (wb_res),
    .pc_sel       (pc_sel),
    .pc_stall     (pc_stall),
    .if_id_stall  (if_id_stall),
    .if_id_flush  (if_id_flush),
    .id_ex_flush  (id_ex_flush)
  );

  // ID/EX takes a bubble on a stall or a taken branch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (id_ex_flush) begin
      id_ex <= '0;
    end else begin
      id_ex.dec     <= dec;
      id_ex.pc      <= if_id_pc;
      id_ex.rs1_val <= rs1_val;
      id_ex.rs2_val <= rs2_val;
    end
  end

  rv_execute u_execute (
    .id_ex     (id_ex),
    .res       (ex_res),
    .pc_sel    (pc_sel),
    .pc_target (pc_target)
  );

  rv_result u_result (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex       (ex_res),
    .mem      (mem_res),
    .wb       (wb_res),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  // Whatever flushes decode also clears execute, or a dead instruction would run
  a_flush_pair: assert property (@(posedge clk) disable iff (!rst_n)
    if_id_flush |-> id_ex_flush);

  // Fetch and decode always freeze together
  a_stall_pair: assert property (@(posedge clk) disable iff (!rst_n)
    pc_stall == if_id_stall);

endmodule

// File: src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
  input  logic [31:0] instr,
  output dec_t        dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_op_e     op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // First pick the operation, anything outside the subset becomes op_nop
  always_comb begin
    op = op_nop;
    case (opcode)
      opc_op: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op = op_add;
          {7'b0100000, 3'b000}: op = op_sub;
          {7'b0000000, 3'b001}: op = op_sll;
          {7'b0000000, 3'b010}: op = op_slt;
          {7'b0000000, 3'b100}: op = op_xor;
          {7'b0000000, 3'b101}: op = op_srl;
          {7'b0000000, 3'b110}: op = op_or;
          {7'b0000000, 3'b111}: op = op_and;
          default:              op = op_nop;
        endcase
      end
      opc_op_imm: begin
        case (funct3)
          3'b000:  op = op_addi;
          3'b100:  op = op_xori;
          3'b110:  op = op_ori;
          3'b111:  op = op_andi;
          default: op = op_nop;
        endcase
      end
      opc_lui: op = op_lui;
      opc_branch: begin
        // Only beq and bne are supported among the branches
        if (funct3 == 3'b000) op = op_beq;
        else if (funct3 == 3'b001) op = op_bne;
      end
      default: op = op_nop;
    endcase
  end

  // Then fill in register use and the immediate by instruction format
  always_comb begin
    dec    = '0;
    dec.op = op;
    case (op)
      op_nop: dec = '0;
      op_addi, op_andi, op_ori, op_xori: begin
        // I format, rs2 bits hold immediate data and must not look like a source
        dec.rd        = instr[11:7];
        dec.rs1       = instr[19:15];
        dec.rs1_used  = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm       = {{20{instr[31]}}, instr[31:20]};
      end
      op_lui: begin
        dec.rd        = instr[11:7];
        dec.reg_write = 1'b1;
        dec.imm       = {instr[31:12], 12'b0};
      end
      op_beq, op_bne: begin
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rs1_used = 1'b1;
        dec.rs2_used = 1'b1;
        dec.imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      default: begin
        // Register-register ALU ops
        dec.rd        = instr[11:7];
        dec.rs1       = instr[19:15];
        dec.rs2       = instr[24:20];
        dec.rs1_used  = 1'b1;
        dec.rs2_used  = 1'b1;
        dec.reg_write = 1'b1;
      end
    endcase
  end

endmodule

// File: src/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
  input  id_ex_t          id_ex,
  output ex_res_t         res,
  output logic            pc_sel,
  output logic [xlen-1:0] pc_target
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            use_imm;
  logic            eq;
  logic [xlen-1:0] alu;

  // Immediate ALU ops take the second operand from the decoded immediate
  assign use_imm = (id_ex.dec.op == op_addi) || (id_ex.dec.op == op_andi) ||
                   (id_ex.dec.op == op_ori) || (id_ex.dec.op == op_xori);

  assign op_a  = id_ex.rs1_val;
  assign op_b  = use_imm ? id_ex.dec.imm : id_ex.rs2_val;
  assign shamt = op_b[4:0];
  assign eq    = (id_ex.rs1_val == id_ex.rs2_val);

  always_comb begin
    case (id_ex.dec.op)
      op_add, op_addi: alu = op_a + op_b;
      op_sub:          alu = op_a - op_b;
      op_and, op_andi: alu = op_a & op_b;
      op_or, op_ori:   alu = op_a | op_b;
      op_xor, op_xori: alu = op_a ^ op_b;
      // Signed compare, result is 0 or 1
      op_slt:          alu = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      op_sll:          alu = op_a << shamt;
      op_srl:          alu = op_a >> shamt;
      op_lui:          alu = id_ex.dec.imm;
      default:         alu = '0;
    endcase
  end

  // Branches are resolved here and redirect fetch in the same cycle
  always_comb begin
    case (id_ex.dec.op)
      op_beq:  pc_sel = eq;
      op_bne:  pc_sel = !eq;
      default: pc_sel = 1'b0;
    endcase
  end

  assign pc_target = id_ex.pc + id_ex.dec.imm;

  assign res.rd        = id_ex.dec.rd;
  assign res.reg_write = id_ex.dec.reg_write;
  assign res.value     = alu;

endmodule

// File: src/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard import rv_pkg::*; #(
  parameter int REGFILE_FWD = 1
) (
  // Instruction in decode and its source registers
  input  dec_t                  dec,
  // Destination of the instruction in EX
  input  logic [reg_addr_w-1:0] ex_rd,
  input  logic                  ex_reg_write,
  // Results waiting in the MEM and WB stage registers
  input  ex_res_t               mem,
  input  ex_res_t               wb,
  // Taken branch resolved in EX
  input  logic                  pc_sel,
  output logic                  pc_stall,
  output logic                  if_id_stall,
  output logic                  if_id_flush,
  output logic                  id_ex_flush
);

  logic ex_hazard;
  logic mem_hazard;
  logic wb_hazard;
  logic data_hazard;

  // True when a writer of rd feeds one of the sources of the decode stage
  // x0 is hard-wired, so a write to it never conflicts
  function automatic logic raw_hit(input logic [reg_addr_w-1:0] rd, input logic we);
    logic hit1;
    logic hit2;
    hit1 = dec.rs1_used && (dec.rs1 == rd);
    hit2 = dec.rs2_used && (dec.rs2 == rd);
    return we && (rd != '0) && (hit1 || hit2);
  endfunction

  // The decode sources are read inside raw_hit, so the compares follow them here
  always_comb begin
    ex_hazard  = raw_hit(ex_rd, ex_reg_write);
    mem_hazard = raw_hit(mem.rd, mem.reg_write);
    // The register file covers WB itself when it forwards its write port
    wb_hazard  = (REGFILE_FWD == 0) && raw_hit(wb.rd, wb.reg_write);
  end

  assign data_hazard = ex_hazard || mem_hazard || wb_hazard;

  // On a data hazard the consumer waits in decode while a bubble goes to EX
  assign pc_stall    = data_hazard;
  assign if_id_stall = data_hazard;

  // A taken branch kills the two younger instructions in IF/ID and ID/EX
  assign if_id_flush = pc_sel;
  assign id_ex_flush = data_hazard || pc_sel;

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

  // Data path width and register index width of the core
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // RV32I major opcodes the decoder understands
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  // All-zero word has no valid opcode, so it decodes as a no-op
  localparam logic [31:0] instr_bubble = 32'h0000_0000;

  // Internal operation codes, op_nop must stay at zero so that a cleared
  // stage register is a bubble
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_xor  = 4'd5,
    op_slt  = 4'd6,
    op_sll  = 4'd7,
    op_srl  = 4'd8,
    op_addi = 4'd9,
    op_andi = 4'd10,
    op_ori  = 4'd11,
    op_xori = 4'd12,
    op_lui  = 4'd13,
    op_beq  = 4'd14,
    op_bne  = 4'd15
  } rv_op_e;

  // Decoded instruction as it leaves the ID stage
  typedef struct packed {
    rv_op_e                op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic                  rs1_used;
    logic                  rs2_used;
    logic                  reg_write;
    logic [xlen-1:0]       imm;
  } dec_t;

  // Contents of the ID/EX pipeline register
  typedef struct packed {
    dec_t            dec;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
  } id_ex_t;

  // Result of execute, also held by the MEM and WB stage registers
  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic                  reg_write;
    logic [xlen-1:0]       value;
  } ex_res_t;

endpackage

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; #(
  parameter int REGFILE_FWD = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  output logic [xlen-1:0]       rs1_val,
  output logic [xlen-1:0]       rs2_val,
  input  ex_res_t               wb
);

  logic [xlen-1:0] regs [32];
  logic            wr_en;
  logic            fwd_rs1;
  logic            fwd_rs2;

  // x0 is never written, even when the writeback port reports it
  assign wr_en = wb.reg_write && (wb.rd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wr_en) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // With forwarding, a read in the WB cycle sees the value being written
  assign fwd_rs1 = (REGFILE_FWD != 0) && wr_en && (wb.rd == rs1);
  assign fwd_rs2 = (REGFILE_FWD != 0) && wr_en && (wb.rd == rs2);

  // x0 reads entry 0, which is cleared at reset and never written or forwarded
  assign rs1_val = fwd_rs1 ? wb.value : regs[rs1];
  assign rs2_val = fwd_rs2 ? wb.value : regs[rs2];

  // Reads of x0 stay zero whatever was retired to it earlier
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    ((rs1 == '0) |-> (rs1_val == '0)) and ((rs2 == '0) |-> (rs2_val == '0)));

endmodule

// File: src/rv_result.sv
`timescale 1ns/1ps

module rv_result import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_res_t               ex,
  output ex_res_t               mem,
  output ex_res_t               wb,
  output logic                  wb_valid,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data
);

  // EX/MEM register, a data memory access would be added after it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem <= '0;
    end else begin
      mem <= ex;
    end
  end

  // MEM/WB register, its contents are written to the register file
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb <= '0;
    end else begin
      wb <= mem;
    end
  end

  // Every retiring write is visible outside, x0 included
  assign wb_valid = wb.reg_write;
  assign wb_rd    = wb.rd;
  assign wb_data  = wb.value;

  // Both stage registers start as bubbles, so nothing retires right after reset
  a_no_wb_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !wb_valid ##1 !wb_valid);

endmodule
